/* filelist.f */
+incdir+logic
logic/fma16Pkg.sv
logic/operandUnpack.sv
logic/productUnit.sv
logic/alignAdder.sv
logic/normalizer.sv
logic/rounder.sv
logic/specialCaseResolver.sv
logic/fma16.sv
sim/fma16_assert.sv
sim/fma16_tb.sv

/* Bender.yml */
package:
  name: fma16

sources:
  - include_dirs:
      - logic
    files:
      - logic/fma16Pkg.sv
      - logic/operandUnpack.sv
      - logic/productUnit.sv
      - logic/alignAdder.sv
      - logic/normalizer.sv
      - logic/rounder.sv
      - logic/specialCaseResolver.sv
      - logic/fma16.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/fma16_assert.sv
      - sim/fma16_tb.sv

/* sim/fma16_tb.sv */
// FMA16 testbench, directed tests checked against integer and IEEE half encoding rules
`timescale 1ns/1ps
`include "fma16_defines.svh"

module fma16_tb;
    localparam int ClkPeriod   = 100;
    localparam int DriveDelay  = 5;
    localparam int ResetCycles = 5;
    localparam int NumRandom   = 20;
    localparam int NumOps      = 3 * NumRandom + 25;   // Random groups plus directed ops
    localparam int CyclesPerOp = 2;
    localparam int TimeoutNs   = (ResetCycles + NumOps * CyclesPerOp + 20) * ClkPeriod;

    logic                   clk;
    logic                   reset;
    fma16Pkg::halfWord_t    operandA, operandB, operandC;
    logic                   mul, add;
    fma16Pkg::roundMode_t   roundMode;
    fma16Pkg::halfWord_t    result;
    fma16Pkg::fmaFlags_t    flags;
    string                  currentTest;

    fma16 fma16_i (.clk, .reset, .operandA, .operandB, .operandC, .mul, .add,
        .roundMode, .result, .flags);

    bind fma16 fma16_assert fma16Assert_i (.clk, .reset, .result, .flags);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired before all tests completed");
        $display("TB FAILED");
        $fatal(1, "Simulation timeout");
    end

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s in %s: got 0x%h, expected 0x%h",
                     name, currentTest, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Exact half encoding of an integer below 2048 in magnitude
    function automatic logic [15:0] encodeInt(input int value);
        int                     mag;
        int                     msb;
        int                     shifted;
        logic                   sign;
        logic [15:0]            word;
        sign = value < 0;
        mag  = sign ? -value : value;
        word = 16'h0000;
        if (mag != 0) begin
            msb = 0;
            for (int i = 0; i < 11; i++) begin
                if ((mag >> i) & 1) begin
                    msb = i;
                end
            end
            shifted = mag << (`FMA_FRAC_W - msb);   // Leading one to the hidden position
            word    = {sign, fma16Pkg::expField_t'(msb + `FMA_BIAS), shifted[9:0]};
        end
        return word;
    endfunction

    // One operation, answer checked one edge after the inputs change
    task automatic runOp(input logic [15:0] a, input logic [15:0] b, input logic [15:0] c,
                         input logic m, input logic ad, input logic [1:0] mode,
                         input logic [15:0] expResult, input logic [3:0] expFlags);
        @(posedge clk);
        #(DriveDelay);
        operandA  = a;
        operandB  = b;
        operandC  = c;
        mul       = m;
        add       = ad;
        roundMode = mode;
        @(posedge clk);
        #1;
        checkValue("result", result, expResult);
        checkValue("flags", 16'(flags), 16'(expFlags));
    endtask

    task automatic resetLatency();
        currentTest = "reset and latency";
        checkValue("result", result, 16'h0000);
        checkValue("flags", 16'(flags), 16'h0000);
        @(posedge clk);
        #1;
        checkValue("result", result, 16'h0000);     // First edge after release
        checkValue("flags", 16'(flags), 16'h0000);
        #(DriveDelay - 1);
        operandA = encodeInt(3);
        operandB = encodeInt(5);
        mul      = 1'b1;
        #(ClkPeriod / 2);
        checkValue("result", result, 16'h0000);     // Not captured yet
        @(posedge clk);
        #1;
        checkValue("result", result, encodeInt(15));
        checkValue("flags", 16'(flags), 16'h0000);
    endtask

    task automatic mulOnly();
        int a;
        int b;
        currentTest = "multiply only";
        for (int n = 0; n < NumRandom; n++) begin
            a = $urandom_range(31, 1);
            b = $urandom_range(31, 1);
            runOp(encodeInt(a), encodeInt(b), encodeInt(b + 7), 1'b1, 1'b0,
                  2'($urandom_range(3, 0)), encodeInt(a * b), 4'b0000);
        end
    endtask

    task automatic addOnly();
        int a;
        int c;
        currentTest = "add only";
        for (int n = 0; n < NumRandom; n++) begin
            a = $urandom_range(31, 1);
            c = $urandom_range(31, 1);
            runOp(encodeInt(a), encodeInt(a + 3), encodeInt(c), 1'b0, 1'b1,
                  2'($urandom_range(3, 0)), encodeInt(a + c), 4'b0000);
        end
    endtask

    task automatic fmaExact();
        int a;
        int b;
        int c;
        currentTest = "fma exact";
        for (int n = 0; n < NumRandom; n++) begin
            a = $urandom_range(31, 1);
            b = $urandom_range(31, 1);
            c = $urandom_range(1023, 1);
            if ($urandom_range(1, 0) == 1) begin
                c = -c;
            end
            runOp(encodeInt(a), encodeInt(b), encodeInt(c), 1'b1, 1'b1,
                  2'($urandom_range(3, 0)), encodeInt(a * b + c), 4'b0000);
        end
        runOp(encodeInt(7), encodeInt(9), encodeInt(-63), 1'b1, 1'b1, 2'b01, 16'h0000, 4'b0000);
        runOp(encodeInt(-6), encodeInt(5), encodeInt(30), 1'b1, 1'b1, 2'b01, 16'h0000, 4'b0000);
        runOp(encodeInt(-6), encodeInt(5), encodeInt(40), 1'b1, 1'b1, 2'b00, encodeInt(10),
              4'b0000);
    endtask

    // (1+2^-10)^2 leaves a 2^-20 tail below half an ulp, so only directed modes round up
    task automatic roundingModes();
        logic   neg;
        logic   up;
        currentTest = "rounding modes";
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < 2; s++) begin
                neg = s[0];
                up  = (m == 3 && !neg) || (m == 2 && neg);
                runOp({neg, 15'h3C01}, 16'h3C01, 16'h0000, 1'b1, 1'b1, 2'(m),
                      {neg, 15'h3C02} + 16'(up), 4'b0001);
            end
        end
    endtask

    task automatic specialInputs();
        currentTest = "special cases";
        runOp(16'h7E00, 16'h3C00, 16'h0000, 1'b1, 1'b1, 2'b01, `FMA_QNAN, 4'b0000);
        runOp(16'h3C00, 16'h7D00, 16'h0000, 1'b1, 1'b1, 2'b01, `FMA_QNAN, 4'b1000);
        runOp(16'h3C00, 16'h3C00, 16'h7C01, 1'b1, 1'b1, 2'b01, `FMA_QNAN, 4'b1000);
        runOp(16'h3C00, 16'h3C00, 16'h7E01, 1'b1, 1'b1, 2'b01, `FMA_QNAN, 4'b0000);
        runOp(16'h0000, 16'h7C00, 16'h0000, 1'b1, 1'b1, 2'b01, `FMA_QNAN, 4'b1000);
        runOp(16'h7C00, 16'h3C00, 16'hFC00, 1'b1, 1'b1, 2'b01, `FMA_QNAN, 4'b1000);
        runOp(16'h7C00, 16'h3C00, 16'h3C00, 1'b1, 1'b1, 2'b01, {1'b0, `FMA_INF_MAG}, 4'b0000);
    endtask

    task automatic productOverflow();
        logic [15:0] expected;
        currentTest = "overflow";
        for (int m = 0; m < 4; m++) begin
            expected = (m == 1 || m == 3) ? {1'b0, `FMA_INF_MAG} : {1'b0, `FMA_MAXNUM_MAG};
            runOp(encodeInt(256), encodeInt(512), 16'h0000, 1'b1, 1'b0, 2'(m), expected,
                  4'b0101);
        end
    endtask

    initial begin
        currentTest = "reset";
        reset       = 1'b1;
        operandA    = '0;
        operandB    = '0;
        operandC    = '0;
        mul         = 1'b0;
        add         = 1'b0;
        roundMode   = 2'b00;
        void'($urandom(92455));
        repeat (ResetCycles) @(posedge clk);
        #(DriveDelay);
        reset = 1'b0;
        resetLatency();
        mulOnly();
        addOnly();
        fmaExact();
        roundingModes();
        specialInputs();
        productOverflow();
        @(posedge clk);
        #1;
        if (fma16_i.fma16Assert_i.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "Assertion failures during the run");
        end
    end

endmodule

/* sim/fma16_assert.sv */
// FMA16 output assertions, bound into the top level
`timescale 1ns/1ps
`include "fma16_defines.svh"

module fma16_assert (
    input logic                 clk,
    input logic                 reset,
    input fma16Pkg::halfWord_t  result,
    input fma16Pkg::fmaFlags_t  flags
);
    int resetFails   = 0;
    int invalidFails = 0;
    int unknownFails = 0;
    int failCount;

    assign failCount = resetFails + invalidFails + unknownFails;

    // Output register cleared by every reset edge
    resetClears: assert property (@(posedge clk) reset |=> (result == '0) && (flags == '0))
        else begin
            resetFails++;
            $error("Outputs not zero on the edge after reset");
        end

    invalidGivesQnan: assert property (@(posedge clk) disable iff (reset)
        flags[3] |-> (result == `FMA_QNAN))
        else begin
            invalidFails++;
            $error("Invalid flag set without the quiet NaN result");
        end

    outputsKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({result, flags}))   // Every input is driven, so no X may leak out
        else begin
            unknownFails++;
            $error("Unknown value on result or flags");
        end

endmodule

/* logic/fma16.sv */
// FMA16 top, half-precision A*B+C datapath with a registered result
`timescale 1ns/1ps
`include "fma16_defines.svh"

module fma16 (
    input  logic                    clk,
    input  logic                    reset,
    input  fma16Pkg::halfWord_t     operandA,
    input  fma16Pkg::halfWord_t     operandB,
    input  fma16Pkg::halfWord_t     operandC,
    input  logic                    mul,
    input  logic                    add,
    input  fma16Pkg::roundMode_t    roundMode,
    output fma16Pkg::halfWord_t     result,
    output fma16Pkg::fmaFlags_t     flags
);
    logic                       signA, signB, signC;
    fma16Pkg::expField_t        expA, expB, expC;
    fma16Pkg::significand_t     sigA, sigB, sigC;
    logic                       nanA, nanB, nanC, signalingNan;
    logic                       productInputZero, productInputInf, zeroTimesInf, infC;

    logic                       productSign;
    fma16Pkg::productExp_t      productExp;
    fma16Pkg::productSig_t      productSig;
    logic                       expOverflow, expUnderflow, expNegative;
    logic                       productExpAllOnes;

    logic                       subtract, stickyA, stickyB, sumSign;
    fma16Pkg::expField_t        sumExp;
    fma16Pkg::sumSig_t          sumSig;

    fma16Pkg::sumSig_t          normSig;
    fma16Pkg::expField_t        normExp;
    logic                       normSign, normOverflow;

    logic                       preRoundOverflow;
    fma16Pkg::expField_t        roundedExp;
    logic [`FMA_FRAC_W-1:0]     roundedFrac;
    logic                       inexact, roundOverflow;

    fma16Pkg::halfWord_t        nextResult;
    fma16Pkg::fmaFlags_t        nextFlags;

    operandUnpack operandUnpack_i (.operandA, .operandB, .operandC, .mul, .add,
        .signA, .signB, .signC, .expA, .expB, .expC, .sigA, .sigB, .sigC,
        .nanA, .nanB, .nanC, .signalingNan, .productInputZero, .productInputInf,
        .zeroTimesInf, .infC);

    productUnit productUnit_i (.signA, .signB, .expA, .expB, .sigA, .sigB,
        .productInputZero, .productSign, .productExp, .productSig,
        .expOverflow, .expUnderflow, .expNegative);

    // Non-negative product exponent that lands on the inf/NaN code
    assign productExpAllOnes = ~productExp[`FMA_EXP_W] & (&productExp[`FMA_EXP_W-1:0]);

    alignAdder alignAdder_i (.productSign, .productExp, .productSig, .expNegative,
        .expOverflow, .productInputZero, .productInputInf, .signC, .expC, .sigC,
        .subtract, .stickyA, .stickyB, .sumSign, .sumExp, .sumSig);

    normalizer normalizer_i (.sumSig, .sumExp, .sumSign, .subtract, .expOverflow,
        .expUnderflow, .productInputZero, .productSign, .signC,
        .normSig, .normExp, .normSign, .normOverflow);

    assign preRoundOverflow = expOverflow | normOverflow;

    rounder rounder_i (.roundMode, .normSign, .normExp, .normSig, .stickyA, .stickyB,
        .preRoundOverflow, .roundedExp, .roundedFrac, .inexact, .roundOverflow);

    specialCaseResolver specialCaseResolver_i (.nanA, .nanB, .nanC, .signalingNan,
        .zeroTimesInf, .productInputInf, .infC, .signC, .sigC, .subtract, .productSign,
        .inexact, .expOverflow, .productExpAllOnes, .expUnderflow, .normOverflow,
        .roundOverflow, .normSign, .roundedExp, .roundedFrac,
        .result(nextResult), .flags(nextFlags));

    // One-cycle output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= nextResult;
            flags  <= nextFlags;
        end
    end

endmodule

/* logic/specialCaseResolver.sv */
// Special-case resolver for NaN and infinity results, also assembles the flags
`timescale 1ns/1ps
`include "fma16_defines.svh"

module specialCaseResolver (
    input  logic                    nanA,
    input  logic                    nanB,
    input  logic                    nanC,
    input  logic                    signalingNan,
    input  logic                    zeroTimesInf,
    input  logic                    productInputInf,
    input  logic                    infC,
    input  logic                    signC,
    input  fma16Pkg::significand_t  sigC,
    input  logic                    subtract,
    input  logic                    productSign,
    input  logic                    inexact,
    input  logic                    expOverflow,
    input  logic                    productExpAllOnes,
    input  logic                    expUnderflow,
    input  logic                    normOverflow,
    input  logic                    roundOverflow,
    input  logic                    normSign,
    input  fma16Pkg::expField_t     roundedExp,
    input  logic [`FMA_FRAC_W-1:0]  roundedFrac,
    output fma16Pkg::halfWord_t     result,
    output fma16Pkg::fmaFlags_t     flags
);
    localparam fma16Pkg::halfWord_t         Qnan   = `FMA_QNAN;
    localparam logic [`FMA_WORD_W-2:0]      InfMag = `FMA_INF_MAG;

    logic overflow;
    logic underflow;
    logic inexactAll;

    assign overflow   = expOverflow | productExpAllOnes | normOverflow | roundOverflow;
    assign underflow  = expUnderflow;
    assign inexactAll = inexact | expOverflow | productExpAllOnes;

    always_comb begin
        if (zeroTimesInf) begin
            result = Qnan;
            flags  = 4'b1000;
        end else if (nanA | nanB | nanC) begin
            result = Qnan;
            flags  = {signalingNan, 3'b000};    // Quiet NaNs pass silently
        end else if (productInputInf & infC & subtract) begin
            result = Qnan;                      // Inf minus inf
            flags  = 4'b1000;
        end else if (productInputInf) begin
            result = {productSign, InfMag};
            flags  = 4'b0000;
        end else if (infC) begin
            // C passes through unchanged
            result = {signC, {`FMA_EXP_W{1'b1}}, sigC[`FMA_FRAC_W-1:0]};
            flags  = 4'b0000;
        end else begin
            result = {normSign, roundedExp, roundedFrac};
            flags  = {1'b0, overflow, underflow, inexactAll};
        end
    end

endmodule

/* logic/rounder.sv */
// Rounder, applies the rounding mode and resolves overflow to inf or maxnum
`timescale 1ns/1ps
`include "fma16_defines.svh"

module rounder (
    input  fma16Pkg::roundMode_t    roundMode,
    input  logic                    normSign,
    input  fma16Pkg::expField_t     normExp,
    input  fma16Pkg::sumSig_t       normSig,
    input  logic                    stickyA,
    input  logic                    stickyB,
    input  logic                    preRoundOverflow,
    output fma16Pkg::expField_t     roundedExp,
    output logic [`FMA_FRAC_W-1:0]  roundedFrac,
    output logic                    inexact,
    output logic                    roundOverflow
);
    localparam logic [`FMA_WORD_W-2:0] InfMag = `FMA_INF_MAG;
    localparam logic [`FMA_WORD_W-2:0] MaxMag = `FMA_MAXNUM_MAG;

    logic                       lsb, guard, roundBit, stickyBit;
    logic                       lostBits;
    logic                       inexactTrunc;
    logic                       roundUp;
    logic [`FMA_FRAC_W+1:0]     sigPlusOne;
    logic                       carry;
    fma16Pkg::expField_t        upExp;
    logic [`FMA_FRAC_W-1:0]     upFrac;

    assign lsb       = normSig[13];
    assign guard     = normSig[12];
    assign roundBit  = normSig[11];
    assign stickyBit = |normSig[10:0];

    assign lostBits     = guard | roundBit | stickyBit;
    assign inexactTrunc = lostBits | stickyA | stickyB;

    always_comb begin
        case (roundMode)
            2'b01:   roundUp = preRoundOverflow | (guard & (lsb | roundBit | stickyBit));
            2'b10:   roundUp = normSign & (preRoundOverflow | lostBits);
            2'b11:   roundUp = ~normSign & (preRoundOverflow | lostBits);
            default: roundUp = 1'b0;    // Toward zero
        endcase
    end

    // Increment, shifting down one place on carry-out
    assign sigPlusOne      = {1'b0, normSig[23:13]} + 12'd1;
    assign {carry, upExp}  = {1'b0, normExp} + {5'd0, sigPlusOne[11]};
    assign upFrac          = sigPlusOne[11] ? sigPlusOne[10:1] : sigPlusOne[9:0];

    always_comb begin
        inexact       = inexactTrunc;
        roundOverflow = 1'b0;
        if (preRoundOverflow) begin
            {roundedExp, roundedFrac} = roundUp ? InfMag : MaxMag;
        end else if (roundUp) begin
            if (carry | (&upExp)) begin     // Rounded past maxnum
                {roundedExp, roundedFrac} = InfMag;
                roundOverflow             = 1'b1;
            end else begin
                roundedExp  = upExp;
                roundedFrac = upFrac;
            end
        end else begin
            roundedExp  = normExp;
            roundedFrac = normSig[22:13];
        end
    end

endmodule

/* logic/normalizer.sv */
// Normalizer, moves the leading one to the top and fixes up the exponent
`timescale 1ns/1ps

module normalizer (
    input  fma16Pkg::sumSig_t       sumSig,
    input  fma16Pkg::expField_t     sumExp,
    input  logic                    sumSign,
    input  logic                    subtract,
    input  logic                    expOverflow,
    input  logic                    expUnderflow,
    input  logic                    productInputZero,
    input  logic                    productSign,
    input  logic                    signC,
    output fma16Pkg::sumSig_t       normSig,
    output fma16Pkg::expField_t     normExp,
    output logic                    normSign,
    output logic                    normOverflow
);
    logic [4:0] leadPos;
    logic [4:0] shiftAmt;
    logic [6:0] expWide;
    logic       sumZero;
    logic       zeroSign;

    // Bit 23 is a real carry only on addition, bit 0 is sticky only
    assign sumZero = ~((sumSig[23] & ~subtract) | (|sumSig[22:1])) & ~expOverflow;

    assign zeroSign = expUnderflow ? productSign : (productInputZero & productSign & signC);

    // Priority encoder, highest set bit wins
    always_comb begin
        leadPos = 5'd0;
        for (int i = 1; i < 23; i++) begin
            if (sumSig[i]) begin
                leadPos = 5'(i);
            end
        end
        if (sumSig[23] & ~subtract) begin
            leadPos = 5'd23;
        end
    end

    assign shiftAmt = 5'd23 - leadPos;
    assign expWide  = {2'b00, sumExp} + {2'b00, leadPos} - 7'd21;  // Unit bit sits at 21

    always_comb begin
        if (sumZero) begin
            normSig      = '0;
            normExp      = '0;
            normSign     = zeroSign;
            normOverflow = 1'b0;
        end else begin
            normSig      = sumSig << shiftAmt;
            normExp      = expWide[4:0];
            normSign     = sumSign;
            normOverflow = ~expWide[6] & (expWide[5] | (&expWide[4:0]));
        end
    end

endmodule

/* logic/alignAdder.sv */
// Alignment and add, shifts the smaller operand with sticky capture and sums
`timescale 1ns/1ps

module alignAdder (
    input  logic                    productSign,
    input  fma16Pkg::productExp_t   productExp,
    input  fma16Pkg::productSig_t   productSig,
    input  logic                    expNegative,
    input  logic                    expOverflow,
    input  logic                    productInputZero,
    input  logic                    productInputInf,
    input  logic                    signC,
    input  fma16Pkg::expField_t     expC,
    input  fma16Pkg::significand_t  sigC,
    output logic                    subtract,
    output logic                    stickyA,
    output logic                    stickyB,
    output logic                    sumSign,
    output fma16Pkg::expField_t     sumExp,
    output fma16Pkg::sumSig_t       sumSig
);
    logic [6:0]             expDiff;
    logic                   cGreater;
    logic [6:0]             shiftA;
    logic [6:0]             shiftB;
    logic [41:0]            shiftedProd;    // 22 kept bits over 20 guard bits
    logic [41:0]            shiftedC;
    fma16Pkg::productSig_t  opA, opB;
    logic [22:0]            termB;
    fma16Pkg::sumSig_t      standardSum, reversedSum;
    logic                   useReversed;

    // Signed exponent difference, product minus C
    assign expDiff  = {productExp[5], productExp} - {2'b00, expC};
    assign cGreater = expDiff[6] | expNegative;

    assign shiftA = cGreater ? -expDiff : 7'd0;
    assign shiftB = cGreater ? 7'd0 : expDiff;

    // C's leading one lines up with the product's unit bit
    assign shiftedProd = {productSig, 20'b0} >> shiftA;
    assign shiftedC    = {1'b0, sigC, 30'b0} >> shiftB;

    assign opA = shiftedProd[41:20];
    assign opB = shiftedC[41:20];

    // Low bits lost, or a non-zero operand pushed far out
    assign stickyA = (|shiftedProd[19:0]) | (~productInputZero & (shiftA >= 7'd20));
    assign stickyB = (|shiftedC[19:0]) | ((|sigC) & (shiftB >= 7'd20));

    assign subtract = productSign ^ signC;
    assign termB    = subtract ? ~{opB, stickyB} : {opB, stickyB};

    assign standardSum = {1'b0, opA, stickyA} + {1'b0, termB} + 24'(subtract);
    assign reversedSum = {1'b0, opB, stickyB} - {1'b0, opA, stickyA};

    // C minus product when that is not negative
    assign useReversed = subtract & ~reversedSum[23];

    assign sumSign = productSign ^ (useReversed & ~productInputInf & ~expOverflow);
    assign sumExp  = cGreater ? expC : productExp[4:0];
    assign sumSig  = useReversed ? reversedSum : standardSum;

endmodule

/* logic/productUnit.sv */
// Product stage, multiplies significands and unbiases the exponent sum
`timescale 1ns/1ps
`include "fma16_defines.svh"

module productUnit (
    input  logic                    signA,
    input  logic                    signB,
    input  fma16Pkg::expField_t     expA,
    input  fma16Pkg::expField_t     expB,
    input  fma16Pkg::significand_t  sigA,
    input  fma16Pkg::significand_t  sigB,
    input  logic                    productInputZero,
    output logic                    productSign,
    output fma16Pkg::productExp_t   productExp,
    output fma16Pkg::productSig_t   productSig,
    output logic                    expOverflow,
    output logic                    expUnderflow,
    output logic                    expNegative
);
    localparam fma16Pkg::productExp_t Bias = `FMA_BIAS;

    fma16Pkg::productExp_t expSum;

    assign expSum      = {1'b0, expA} + {1'b0, expB};
    assign productSign = signA ^ signB;

    // A zero input clears both fields
    assign productExp = productInputZero ? '0 : expSum - Bias;
    assign productSig = productInputZero ? '0 : sigA * sigB;

    // Carry of the raw sum separates a too-large exponent from a negative one
    assign expOverflow  = productExp[`FMA_EXP_W] & expSum[`FMA_EXP_W];
    assign expUnderflow = productExp[`FMA_EXP_W] & ~expSum[`FMA_EXP_W];
    assign expNegative  = productExp[`FMA_EXP_W];

endmodule

/* logic/operandUnpack.sv */
// Operand unpack, applies the mul/add substitutions and classifies each operand
`timescale 1ns/1ps
`include "fma16_defines.svh"

module operandUnpack (
    input  fma16Pkg::halfWord_t     operandA,
    input  fma16Pkg::halfWord_t     operandB,
    input  fma16Pkg::halfWord_t     operandC,
    input  logic                    mul,
    input  logic                    add,
    output logic                    signA,
    output logic                    signB,
    output logic                    signC,
    output fma16Pkg::expField_t     expA,
    output fma16Pkg::expField_t     expB,
    output fma16Pkg::expField_t     expC,
    output fma16Pkg::significand_t  sigA,
    output fma16Pkg::significand_t  sigB,
    output fma16Pkg::significand_t  sigC,
    output logic                    nanA,
    output logic                    nanB,
    output logic                    nanC,
    output logic                    signalingNan,
    output logic                    productInputZero,
    output logic                    productInputInf,
    output logic                    zeroTimesInf,
    output logic                    infC
);
    localparam fma16Pkg::halfWord_t One =
        {1'b0, fma16Pkg::expField_t'(`FMA_BIAS), {`FMA_FRAC_W{1'b0}}};

    fma16Pkg::halfWord_t effB, effC;
    logic zeroA, zeroB, infA, infB;

    assign effB = mul ? operandB : One;     // B becomes 1.0
    assign effC = add ? operandC : '0;      // C becomes +0

    assign signA = operandA[`FMA_WORD_W-1];
    assign signB = effB[`FMA_WORD_W-1];
    assign signC = effC[`FMA_WORD_W-1];

    assign expA = operandA[`FMA_WORD_W-2:`FMA_FRAC_W];
    assign expB = effB[`FMA_WORD_W-2:`FMA_FRAC_W];
    assign expC = effC[`FMA_WORD_W-2:`FMA_FRAC_W];

    // A and B are taken as normal, C gets its hidden bit only when non-zero
    assign sigA = {1'b1, operandA[`FMA_FRAC_W-1:0]};
    assign sigB = {1'b1, effB[`FMA_FRAC_W-1:0]};
    assign sigC = {(|effC[`FMA_WORD_W-2:0]), effC[`FMA_FRAC_W-1:0]};

    assign nanA = (&expA) & (|sigA[`FMA_FRAC_W-1:0]);
    assign nanB = (&expB) & (|sigB[`FMA_FRAC_W-1:0]);
    assign nanC = (&expC) & (|sigC[`FMA_FRAC_W-1:0]);

    // Signaling when the top fraction bit is clear
    assign signalingNan = (nanA & ~sigA[`FMA_FRAC_W-1]) | (nanB & ~sigB[`FMA_FRAC_W-1])
                        | (nanC & ~sigC[`FMA_FRAC_W-1]);

    assign zeroA = ~(|operandA[`FMA_WORD_W-2:0]);
    assign zeroB = ~(|effB[`FMA_WORD_W-2:0]);
    assign infA  = (&expA) & ~(|sigA[`FMA_FRAC_W-1:0]);
    assign infB  = (&expB) & ~(|sigB[`FMA_FRAC_W-1:0]);
    assign infC  = (&expC) & ~(|sigC[`FMA_FRAC_W-1:0]);

    assign productInputZero = zeroA | zeroB;
    assign productInputInf  = infA | infB;
    assign zeroTimesInf     = (zeroA & infB) | (zeroB & infA);

endmodule

/* logic/fma16Pkg.sv */
// FMA16 package with the vector types shared by the datapath stages
`include "fma16_defines.svh"

package fma16Pkg;

    typedef logic [`FMA_WORD_W-1:0]     halfWord_t;
    typedef logic [`FMA_EXP_W-1:0]      expField_t;
    typedef logic [`FMA_EXP_W:0]        productExp_t;   // Top bit is sign or overflow
    typedef logic [`FMA_FRAC_W:0]       significand_t;  // Hidden bit included
    typedef logic [2*`FMA_FRAC_W+1:0]   productSig_t;
    typedef logic [2*`FMA_FRAC_W+3:0]   sumSig_t;       // Carry, product bits, sticky

    // 00 toward zero, 01 nearest even, 10 toward negative, 11 toward positive
    typedef logic [1:0]                 roundMode_t;

    // Invalid, overflow, underflow, inexact
    typedef logic [3:0]                 fmaFlags_t;

endpackage

/* logic/fma16_defines.svh */
// Half-precision FMA constants for field widths, bias and special encodings
`ifndef FMA16_DEFINES_SVH
`define FMA16_DEFINES_SVH

`define FMA_WORD_W      16
`define FMA_EXP_W       5
`define FMA_FRAC_W      10
`define FMA_BIAS        15

// Quiet NaN, sign clear and top fraction bit set
`define FMA_QNAN        16'h7E00

// Magnitudes without the sign bit
`define FMA_INF_MAG     15'h7C00
`define FMA_MAXNUM_MAG  15'h7BFF

`endif
